//--- list.f
verilog/spi_frame_pkg.sv
verilog/serial_cmd_pkg.sv
verilog/sclk_timer.sv
verilog/spi_sequencer.sv
verilog/spi_shifter.sv
verilog/select_decoder.sv
verilog/serial_ctrl_top.sv
tests/tb_clock.sv
tests/serial_ctrl_chk.sv
tests/serial_ctrl_tb.sv

//--- tests/serial_ctrl_chk.sv
// -------------------------------------------------------------------------
// pin rules of the select decoder, checked on every lclk edge out of reset
// bound into every select_decoder instance
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module serial_ctrl_chk #(
  parameter int n_adc      = 6,
  parameter int n_dac_bus  = 3,
  parameter int n_dac_chip = 3
) (
  input wire                                  lclk,
  input wire                                  lclk_rst,
  input wire [n_adc-1:0]                      i_adc_sen,
  input wire                                  i_adc_sclk,
  input wire [n_dac_bus-1:0]                  i_dac_sclk,
  input wire [n_dac_bus-1:0][n_dac_chip-1:0]  i_dac_nsync
);

  // one converter selected at most
  a_one_select: assert property (@(posedge lclk) disable iff (lclk_rst)
    $countones({~i_adc_sen, ~i_dac_nsync}) <= 1)
    else $error("more than one select low");

  // idle buses keep SCLK high
  for (genvar b = 0; b < n_dac_bus; b++) begin : g_bus
    a_bus_idle: assert property (@(posedge lclk) disable iff (lclk_rst)
      (&i_dac_nsync[b]) |-> i_dac_sclk[b])
      else $error("DAC SCLK moved on a bus that is not addressed");
  end

  a_adc_idle: assert property (@(posedge lclk) disable iff (lclk_rst)
    (&i_adc_sen) |-> !i_adc_sclk)
    else $error("ADC SCLK high with no SEN low");

endmodule

bind select_decoder serial_ctrl_chk #(
  .n_adc      (n_adc),
  .n_dac_bus  (n_dac_bus),
  .n_dac_chip (n_dac_chip)
) serial_ctrl_chk_i (
  .lclk        (lclk),
  .lclk_rst    (lclk_rst),
  .i_adc_sen   (o_adc_sen),
  .i_adc_sclk  (o_adc_sclk),
  .i_dac_sclk  (o_dac_sclk),
  .i_dac_nsync (o_dac_nsync)
);

`default_nettype wire

//--- tests/serial_ctrl_tb.sv
// -------------------------------------------------------------------------
// runs every command of tests/serial_patterns.mem through serial_ctrl_top
// slave models on the pins rebuild each frame
// built for the default parameters only
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module serial_ctrl_tb;

  localparam int half_period  = 4;
  localparam int n_adc        = 6;
  localparam int n_dac_bus    = 3;
  localparam int n_dac_chip   = 3;
  localparam int n_pat        = 14;
  // longest frame plus setup, hold and pipeline slack
  localparam int frame_cycles = (2 * 32 + 2) * half_period + 4;
  localparam int cycle_limit  = n_pat * (frame_cycles + 40) + 16;

  // one frame as seen on the pins
  typedef struct packed {
    logic [31:0] word;
    logic [8:0]  sel;
    logic [2:0]  buses;
    logic [6:0]  bits;
  } frame_rec_t;

  logic                                    lclk;
  logic                                    lclk_rst;
  logic                                    i_cmd_valid;
  serial_cmd_pkg::serial_cmd_t             i_cmd;
  logic                                    o_cmd_ready;
  logic                                    o_rsp_valid;
  serial_cmd_pkg::serial_rsp_t             o_rsp;
  logic                                    i_rsp_ready;
  logic                                    i_adc_sdout;
  logic [n_adc-1:0]                        o_adc_sen;
  logic                                    o_adc_sclk;
  logic                                    o_adc_sdata;
  logic [n_dac_bus-1:0]                    o_dac_sclk;
  logic [n_dac_bus-1:0]                    o_dac_din;
  logic [n_dac_bus-1:0][n_dac_chip-1:0]    o_dac_nsync;

  logic [31:0] pat_mem [0:5*n_pat-1];
  logic [7:0]  miso_byte;
  frame_rec_t  adc_q[$];
  frame_rec_t  dac_q[$];
  int          cycles;

  tb_clock tb_clock_i (
    .o_lclk     (lclk),
    .o_lclk_rst (lclk_rst)
  );

  serial_ctrl_top #(
    .half_period (half_period),
    .n_adc       (n_adc),
    .n_dac_bus   (n_dac_bus),
    .n_dac_chip  (n_dac_chip)
  ) serial_ctrl_top_i (
    .lclk        (lclk),
    .lclk_rst    (lclk_rst),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd       (i_cmd),
    .o_cmd_ready (o_cmd_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp),
    .i_rsp_ready (i_rsp_ready),
    .i_adc_sdout (i_adc_sdout),
    .o_adc_sen   (o_adc_sen),
    .o_adc_sclk  (o_adc_sclk),
    .o_adc_sdata (o_adc_sdata),
    .o_dac_sclk  (o_dac_sclk),
    .o_dac_din   (o_dac_din),
    .o_dac_nsync (o_dac_nsync)
  );

  task automatic stop_on_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_adc_frame(input spi_frame_pkg::adc_frame_u got,
                                 input spi_frame_pkg::adc_frame_u exp);
    if (got.raw !== exp.raw) begin
      stop_on_error($sformatf("adc frame %h, expected %h", got.raw, exp.raw));
    end
  endtask

  task automatic check_dac_word(input spi_frame_pkg::dac_word_t got,
                                input spi_frame_pkg::dac_word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("dac word %h, expected %h", got, exp));
    end
  endtask

  task automatic check_rsp(input serial_cmd_pkg::serial_rsp_t got,
                           input serial_cmd_pkg::serial_rsp_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("response data %h dev %0d, expected data %h dev %0d",
                              got.data, got.dev, exp.data, exp.dev));
    end
  endtask

  // byte rides in the last 8 bits of the ADC frame
  function automatic logic miso_bit(input int k);
    return (k >= 16 && k < 24) ? miso_byte[23-k] : 1'b0;
  endfunction

  // ADC slave samples on rising SCLK and sets the next MISO bit after each sample
  logic [n_adc-1:0] adc_sen_prev = '1;
  logic             adc_sclk_prev = 1'b0;
  frame_rec_t       adc_rec;
  always @(posedge lclk) begin
    if (!lclk_rst) begin
      if ((&adc_sen_prev) && !(&o_adc_sen)) begin
        adc_rec     = '0;
        adc_rec.sel = 9'(o_adc_sen) | ~9'((1 << n_adc) - 1);
        i_adc_sdout <= miso_bit(0);
      end
      if (o_adc_sclk && !adc_sclk_prev) begin
        adc_rec.word = {adc_rec.word[30:0], o_adc_sdata};
        adc_rec.bits = adc_rec.bits + 1'b1;
        i_adc_sdout <= miso_bit(int'(adc_rec.bits));
      end
      if (!(&adc_sen_prev) && (&o_adc_sen)) begin
        adc_q.push_back(adc_rec);
      end
    end
    adc_sen_prev  = o_adc_sen;
    adc_sclk_prev = o_adc_sclk;
  end

  // DAC slave samples DIN on the falling SCLK of any bus
  logic [n_dac_bus-1:0][n_dac_chip-1:0] dac_nsync_prev = '1;
  logic [n_dac_bus-1:0]                 dac_sclk_prev = '1;
  frame_rec_t                           dac_rec;
  always @(posedge lclk) begin
    if (!lclk_rst) begin
      if ((&dac_nsync_prev) && !(&o_dac_nsync)) begin
        dac_rec     = '0;
        dac_rec.sel = o_dac_nsync;
      end
      for (int b = 0; b < n_dac_bus; b++) begin
        if (!o_dac_sclk[b] && dac_sclk_prev[b]) begin
          dac_rec.word     = {dac_rec.word[30:0], o_dac_din[b]};
          dac_rec.bits     = dac_rec.bits + 1'b1;
          dac_rec.buses[b] = 1'b1;
        end
        // data on a bus marks it as used too
        if (o_dac_din[b]) begin
          dac_rec.buses[b] = 1'b1;
        end
      end
      if (!(&dac_nsync_prev) && (&o_dac_nsync)) begin
        dac_q.push_back(dac_rec);
      end
    end
    dac_nsync_prev = o_dac_nsync;
    dac_sclk_prev  = o_dac_sclk;
  end

  always @(posedge lclk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_idle_pins();
    if (!o_cmd_ready || o_rsp_valid || !(&o_adc_sen) || !(&o_dac_nsync) ||
        o_adc_sclk || o_adc_sdata || !(&o_dac_sclk) || (|o_dac_din)) begin
      stop_on_error("pins not at their idle levels after reset");
    end
  endtask

  task automatic run_cmd(input serial_cmd_pkg::serial_cmd_t cmd, input logic [7:0] mbyte);
    frame_rec_t                  rec;
    serial_cmd_pkg::serial_rsp_t held;
    serial_cmd_pkg::serial_rsp_t exp_rsp;
    spi_frame_pkg::adc_frame_u   exp_frame;
    spi_frame_pkg::adc_frame_u   got_frame;
    int                          delay;
    miso_byte = mbyte;
    i_cmd       <= cmd;
    i_cmd_valid <= 1'b1;
    do @(posedge lclk); while (!o_cmd_ready);
    i_cmd_valid <= 1'b0;
    if (cmd.target == serial_cmd_pkg::adc) begin
      do @(posedge lclk); while (!o_rsp_valid);
      held  = o_rsp;
      delay = $urandom_range(0, 7);
      // back-pressure holds the response and blocks new commands
      repeat (delay) begin
        @(posedge lclk);
        if (!o_rsp_valid || o_cmd_ready) begin
          stop_on_error("response dropped or command accepted under back-pressure");
        end
        check_rsp(o_rsp, held);
      end
      i_rsp_ready <= 1'b1;
      @(posedge lclk);
      i_rsp_ready <= 1'b0;
      while (adc_q.size() == 0) @(posedge lclk);
      rec           = adc_q.pop_front();
      exp_frame.raw = cmd.word[23:0];
      got_frame.raw = rec.word[23:0];
      if (rec.bits != 7'd24) begin
        stop_on_error($sformatf("adc frame had %0d clocks, expected 24", rec.bits));
      end
      if (rec.sel[n_adc-1:0] != ~(n_adc'(1) << cmd.dev)) begin
        stop_on_error($sformatf("wrong SEN pattern %b for adc %0d", rec.sel, cmd.dev));
      end
      check_adc_frame(got_frame, exp_frame);
      exp_rsp.data = mbyte;
      exp_rsp.dev  = cmd.dev;
      check_rsp(held, exp_rsp);
    end else begin
      while (dac_q.size() == 0) @(posedge lclk);
      rec = dac_q.pop_front();
      if (rec.bits != 7'd32 || rec.buses != 3'(1 << cmd.dev)) begin
        stop_on_error($sformatf("dac frame had %0d clocks, clock or data on buses %b",
                                rec.bits, rec.buses));
      end
      if (rec.sel != ~(9'd1 << (cmd.dev * n_dac_chip + cmd.chip))) begin
        stop_on_error($sformatf("wrong nSYNC pattern %b", rec.sel));
      end
      check_dac_word(rec.word, cmd.word);
    end
  endtask

  initial begin
    serial_cmd_pkg::serial_cmd_t cmd;
    cycles      = 0;
    void'($urandom(77));
    i_cmd_valid = 1'b0;
    i_cmd       = '0;
    i_rsp_ready = 1'b0;
    i_adc_sdout = 1'b0;
    miso_byte   = '0;
    $readmemh("tests/serial_patterns.mem", pat_mem);
    @(posedge lclk);
    while (lclk_rst) @(posedge lclk);
    @(posedge lclk);
    check_idle_pins();
    // commands go out back to back as soon as ready returns
    for (int p = 0; p < n_pat; p++) begin
      cmd.target = serial_cmd_pkg::target_e'(pat_mem[5*p][0]);
      cmd.dev    = pat_mem[5*p+1][3:0];
      cmd.chip   = pat_mem[5*p+2][1:0];
      cmd.word   = pat_mem[5*p+3];
      run_cmd(cmd, pat_mem[5*p+4][7:0]);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/serial_patterns.mem
// columns: target (0 adc, 1 dac), device, chip, frame word, adc MISO byte
// adc frames send word[23:0], dac frames ignore the MISO byte
0 0 0 00123456 a5
1 0 0 12345678 00
0 5 0 00abcdef 3c
1 2 2 deadbeef 00
0 3 0 0080ff00 ff
1 1 0 0f0f0f0f 00
1 1 1 f0e1d2c3 00
0 1 0 00000000 01
0 2 0 00ffffff 80
1 2 0 80000001 00
1 0 2 55aa55aa 00
0 4 0 ff5a5a5a 00
1 0 1 a5a5a5a5 00
0 0 0 00c3c3c3 7e

//--- tests/tb_clock.sv
// -------------------------------------------------------------------------
// lclk source, 10 ns period, reset held high for the first 16 rising edges
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic o_lclk,
  output logic o_lclk_rst
);

  initial begin
    o_lclk = 1'b0;
    forever #5 o_lclk = !o_lclk;
  end

  // synchronous release after 16 cycles
  initial begin
    o_lclk_rst = 1'b1;
    repeat (16) @(posedge o_lclk);
    o_lclk_rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- verilog/sclk_timer.sv
// -------------------------------------------------------------------------
// half-bit tick generator for the shared SPI engine
// half_period must be 2 or more, i_nbits is held for the whole frame
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sclk_timer #(
  parameter int half_period = 4
) (
  input  wire                       lclk,
  input  wire                       lclk_rst,
  input  wire                       i_start,
  input  wire spi_frame_pkg::bit_count_t i_nbits,
  output logic                      o_lead_tick,
  output logic                      o_mid_tick,
  output logic                      o_last,
  output logic                      o_phase
);

  localparam int cnt_w = $clog2(half_period);

  // frame segments
  localparam logic [1:0] t_idle  = 2'd0;
  localparam logic [1:0] t_setup = 2'd1;
  localparam logic [1:0] t_bits  = 2'd2;
  localparam logic [1:0] t_hold  = 2'd3;

  logic [1:0]                 seg;
  logic [cnt_w-1:0]           pre_cnt;
  spi_frame_pkg::bit_count_t  bit_cnt;
  logic                       phase;
  logic                       tick;

  // end of each half period
  assign tick = (seg != t_idle) && (pre_cnt == cnt_w'(half_period - 1));

  // mid-bit ends the first half of a bit, every other tick is a lead
  assign o_mid_tick  = tick && (seg == t_bits) && !phase;
  assign o_lead_tick = tick && !((seg == t_bits) && !phase);
  assign o_last      = (seg == t_bits) && (bit_cnt == i_nbits - 1'b1);
  assign o_phase     = phase;

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      seg     <= t_idle;
      pre_cnt <= '0;
      bit_cnt <= '0;
      phase   <= 1'b0;
    end else if (i_start) begin
      seg     <= t_setup;
      pre_cnt <= '0;
      bit_cnt <= '0;
      phase   <= 1'b0;
    end else if (seg != t_idle) begin
      pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
      if (tick) begin
        case (seg)
          t_setup: seg <= t_bits;
          t_bits: begin
            phase <= !phase;
            // second half done, next bit or hold
            if (phase && o_last) begin
              seg <= t_hold;
            end else if (phase) begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          // hold over, timer parks itself
          default: seg <= t_idle;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/select_decoder.sv
// -------------------------------------------------------------------------
// chip selects and per-bus clock/data steering, all outputs registered
// an out-of-range device or chip index leaves every pin at idle
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module select_decoder #(
  parameter int n_adc      = 6,
  parameter int n_dac_bus  = 3,
  parameter int n_dac_chip = 3
) (
  input  wire                              lclk,
  input  wire                              lclk_rst,
  input  wire                              i_active,
  input  wire serial_cmd_pkg::serial_cmd_t i_cmd,
  input  wire                              i_mosi,
  input  wire                              i_phase,
  output logic [n_adc-1:0]                 o_adc_sen,
  output logic                             o_adc_sclk,
  output logic                             o_adc_sdata,
  output logic [n_dac_bus-1:0]             o_dac_sclk,
  output logic [n_dac_bus-1:0]             o_dac_din,
  output logic [n_dac_bus-1:0][n_dac_chip-1:0] o_dac_nsync
);

  logic                 adc_hit;
  logic                 dac_ok;
  logic [n_dac_bus-1:0] bus_hit;

  // ADC port shared, only the SEN is per chip
  assign adc_hit = i_active && (i_cmd.target == serial_cmd_pkg::adc) && (i_cmd.dev < n_adc);
  assign dac_ok  = i_active && (i_cmd.target == serial_cmd_pkg::dac) &&
                   (i_cmd.chip < n_dac_chip);

  always_comb begin
    for (int b = 0; b < n_dac_bus; b++) begin
      bus_hit[b] = dac_ok && (i_cmd.dev == serial_cmd_pkg::dev_idx_t'(b));
    end
  end

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_adc_sen   <= '1;
      o_adc_sclk  <= 1'b0;
      o_adc_sdata <= 1'b0;
      o_dac_sclk  <= '1;
      o_dac_din   <= '0;
      o_dac_nsync <= '1;
    end else begin
      for (int a = 0; a < n_adc; a++) begin
        o_adc_sen[a] <= !(adc_hit && (i_cmd.dev == serial_cmd_pkg::dev_idx_t'(a)));
      end
      // ADC SCLK idles low, rises at mid-bit
      o_adc_sclk  <= adc_hit && i_phase;
      o_adc_sdata <= adc_hit && i_mosi;
      for (int b = 0; b < n_dac_bus; b++) begin
        // DAC SCLK idles high, falls at mid-bit
        o_dac_sclk[b] <= !(bus_hit[b] && i_phase);
        o_dac_din[b]  <= bus_hit[b] && i_mosi;
        for (int c = 0; c < n_dac_chip; c++) begin
          o_dac_nsync[b][c] <= !(bus_hit[b] &&
                                 (i_cmd.chip == serial_cmd_pkg::chip_idx_t'(c)));
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/serial_cmd_pkg.sv
// -------------------------------------------------------------------------
// command and response words of the serial control port
// device is the ADC number or the DAC bus number, chip is DAC only
// -------------------------------------------------------------------------
`default_nettype none

package serial_cmd_pkg;

  // which converter family the frame goes to
  typedef enum logic {
    adc = 1'b0,
    dac = 1'b1
  } target_e;

  typedef logic [3:0] dev_idx_t;
  typedef logic [1:0] chip_idx_t;

  // one queued transfer, ADC frames only send word[23:0]
  typedef struct packed {
    target_e                   target;
    dev_idx_t                  dev;
    chip_idx_t                 chip;
    spi_frame_pkg::frame_word_t word;
  } serial_cmd_t;

  // read back from an ADC frame
  typedef struct packed {
    logic [7:0] data;
    dev_idx_t   dev;
  } serial_rsp_t;

endpackage

`default_nettype wire

//--- verilog/serial_ctrl_top.sv
// -------------------------------------------------------------------------
// serial control path for the ADC3424 and AD5668 converters
// one shared SPI engine, valid/ready on command and response ports
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module serial_ctrl_top #(
  parameter int half_period = 4,
  parameter int n_adc       = 6,
  parameter int n_dac_bus   = 3,
  parameter int n_dac_chip  = 3
) (
  input  wire                              lclk,
  input  wire                              lclk_rst,
  input  wire                              i_cmd_valid,
  input  wire serial_cmd_pkg::serial_cmd_t i_cmd,
  output logic                             o_cmd_ready,
  output logic                             o_rsp_valid,
  output serial_cmd_pkg::serial_rsp_t      o_rsp,
  input  wire                              i_rsp_ready,
  input  wire                              i_adc_sdout,
  output logic [n_adc-1:0]                 o_adc_sen,
  output logic                             o_adc_sclk,
  output logic                             o_adc_sdata,
  output logic [n_dac_bus-1:0]             o_dac_sclk,
  output logic [n_dac_bus-1:0]             o_dac_din,
  output logic [n_dac_bus-1:0][n_dac_chip-1:0] o_dac_nsync
);

  // sequencer to timer
  logic                        start;
  spi_frame_pkg::bit_count_t   nbits;
  logic                        lead_tick;
  logic                        mid_tick;
  logic                        last;
  logic                        phase;
  // sequencer to shifter
  logic                        load;
  spi_frame_pkg::frame_word_t  word;
  logic                        mosi;
  spi_frame_pkg::adc_frame_u   capture;
  // sequencer to decoder
  logic                        active;
  serial_cmd_pkg::serial_cmd_t cur_cmd;

  spi_sequencer spi_sequencer_i (
    .lclk        (lclk),
    .lclk_rst    (lclk_rst),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd       (i_cmd),
    .i_rsp_ready (i_rsp_ready),
    .i_lead_tick (lead_tick),
    .i_mid_tick  (mid_tick),
    .i_last      (last),
    .i_capture   (capture),
    .o_cmd_ready (o_cmd_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp),
    .o_start     (start),
    .o_nbits     (nbits),
    .o_load      (load),
    .o_word      (word),
    .o_active    (active),
    .o_cur_cmd   (cur_cmd)
  );

  sclk_timer #(.half_period(half_period)) sclk_timer_i (
    .lclk        (lclk),
    .lclk_rst    (lclk_rst),
    .i_start     (start),
    .i_nbits     (nbits),
    .o_lead_tick (lead_tick),
    .o_mid_tick  (mid_tick),
    .o_last      (last),
    .o_phase     (phase)
  );

  // ADC SDOUT is the only MISO source
  spi_shifter spi_shifter_i (
    .lclk        (lclk),
    .lclk_rst    (lclk_rst),
    .i_load      (load),
    .i_word      (word),
    .i_nbits     (nbits),
    .i_lead_tick (lead_tick),
    .i_mid_tick  (mid_tick),
    .i_miso      (i_adc_sdout),
    .o_mosi      (mosi),
    .o_capture   (capture)
  );

  select_decoder #(
    .n_adc      (n_adc),
    .n_dac_bus  (n_dac_bus),
    .n_dac_chip (n_dac_chip)
  ) select_decoder_i (
    .lclk        (lclk),
    .lclk_rst    (lclk_rst),
    .i_active    (active),
    .i_cmd       (cur_cmd),
    .i_mosi      (mosi),
    .i_phase     (phase),
    .o_adc_sen   (o_adc_sen),
    .o_adc_sclk  (o_adc_sclk),
    .o_adc_sdata (o_adc_sdata),
    .o_dac_sclk  (o_dac_sclk),
    .o_dac_din   (o_dac_din),
    .o_dac_nsync (o_dac_nsync)
  );

endmodule

`default_nettype wire

//--- verilog/spi_frame_pkg.sv
// -------------------------------------------------------------------------
// frame lengths and word types for the ADC3424 and AD5668 serial ports
// words are sent MSB first and the DAC word is the widest frame
// the ADC read byte sits in the low 8 bits of the 24-bit frame
// -------------------------------------------------------------------------
`default_nettype none

package spi_frame_pkg;

  // frame position counter, wide enough for the 32-bit DAC frame
  typedef logic [5:0] bit_count_t;

  // ADC3424 frame, 16 bit address/command then 8 bit data
  localparam bit_count_t adc_frame_bits = 6'd24;

  // AD5668 frame, write only
  localparam bit_count_t dac_frame_bits = 6'd32;

  // holds either frame, ADC words use the low bits
  typedef logic [dac_frame_bits-1:0] frame_word_t;

  // full AD5668 command word
  typedef logic [dac_frame_bits-1:0] dac_word_t;

  // ADC frame split into its two fields
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
  } adc_fields_t;

  // raw shift view or decoded view of the same 24 bits
  typedef union packed {
    logic [adc_frame_bits-1:0] raw;
    adc_fields_t               fld;
  } adc_frame_u;

endpackage

`default_nettype wire

//--- verilog/spi_sequencer.sv
// -------------------------------------------------------------------------
// command FSM of the shared SPI engine, one frame in flight at a time
// ADC frames return one response and block commands until it is taken
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spi_sequencer (
  input  wire                          lclk,
  input  wire                          lclk_rst,
  input  wire                          i_cmd_valid,
  input  wire serial_cmd_pkg::serial_cmd_t i_cmd,
  input  wire                          i_rsp_ready,
  input  wire                          i_lead_tick,
  input  wire                          i_mid_tick,
  input  wire                          i_last,
  input  wire spi_frame_pkg::adc_frame_u   i_capture,
  output logic                         o_cmd_ready,
  output logic                         o_rsp_valid,
  output serial_cmd_pkg::serial_rsp_t  o_rsp,
  output logic                         o_start,
  output spi_frame_pkg::bit_count_t    o_nbits,
  output logic                         o_load,
  output spi_frame_pkg::frame_word_t   o_word,
  output logic                         o_active,
  output serial_cmd_pkg::serial_cmd_t  o_cur_cmd
);

  localparam logic [2:0] st_idle    = 3'd0;
  localparam logic [2:0] st_setup   = 3'd1;
  localparam logic [2:0] st_shift   = 3'd2;
  localparam logic [2:0] st_hold    = 3'd3;
  localparam logic [2:0] st_respond = 3'd4;

  logic [2:0]                   state;
  logic                         mark;
  logic                         accept;
  serial_cmd_pkg::serial_cmd_t  cur_cmd;
  serial_cmd_pkg::serial_cmd_t  frame_cmd;

  assign accept = (state == st_idle) && i_cmd_valid;

  // new command on the accept cycle, latched copy afterwards
  assign frame_cmd = (state == st_idle) ? i_cmd : cur_cmd;

  assign o_start = accept;
  assign o_load  = accept;
  assign o_word  = frame_cmd.word;
  assign o_nbits = (frame_cmd.target == serial_cmd_pkg::adc) ?
                   spi_frame_pkg::adc_frame_bits : spi_frame_pkg::dac_frame_bits;

  // select drops one cycle before ready comes back
  assign o_active = ((state == st_setup) || (state == st_shift) || (state == st_hold)) &&
                    !((state == st_hold) && mark);
  assign o_cur_cmd = cur_cmd;

  assign o_cmd_ready = (state == st_idle);
  assign o_rsp_valid = (state == st_respond);
  // capture is quiet after the frame so the response holds
  assign o_rsp.data = i_capture.fld.data;
  assign o_rsp.dev  = cur_cmd.dev;

  always_ff @(posedge lclk) begin
    if (accept) begin
      cur_cmd <= i_cmd;
    end
  end

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      state <= st_idle;
      mark  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (i_cmd_valid) begin
            state <= st_setup;
          end
        end
        // first lead tick closes the setup half period
        st_setup: begin
          if (i_lead_tick) begin
            state <= st_shift;
          end
        end
        // mark once the final bit is sampled, leave at its end
        st_shift: begin
          if (i_mid_tick && i_last) begin
            mark <= 1'b1;
          end
          if (i_lead_tick && mark) begin
            mark  <= 1'b0;
            state <= st_hold;
          end
        end
        // mark closes the hold, one idle cycle follows
        st_hold: begin
          if (mark) begin
            mark  <= 1'b0;
            state <= (cur_cmd.target == serial_cmd_pkg::adc) ? st_respond : st_idle;
          end else if (i_lead_tick) begin
            mark <= 1'b1;
          end
        end
        st_respond: begin
          if (i_rsp_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/spi_shifter.sv
// -------------------------------------------------------------------------
// MOSI shift register and MISO capture for both frame types
// shorter frames are left-justified so MOSI is always the top bit
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spi_shifter (
  input  wire                          lclk,
  input  wire                          lclk_rst,
  input  wire                          i_load,
  input  wire spi_frame_pkg::frame_word_t  i_word,
  input  wire spi_frame_pkg::bit_count_t   i_nbits,
  input  wire                          i_lead_tick,
  input  wire                          i_mid_tick,
  input  wire                          i_miso,
  output logic                         o_mosi,
  output spi_frame_pkg::adc_frame_u    o_capture
);

  spi_frame_pkg::frame_word_t  shreg;
  spi_frame_pkg::adc_frame_u   cap;
  logic                        primed;

  // outgoing bits
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      shreg  <= '0;
      primed <= 1'b0;
    end else if (i_load) begin
      // drop the unused top bits of a short frame
      shreg  <= i_word << (spi_frame_pkg::dac_frame_bits - i_nbits);
      primed <= 1'b0;
    end else if (i_lead_tick) begin
      // bit 0 is already on the line at the first lead
      if (primed) begin
        shreg <= {shreg[spi_frame_pkg::dac_frame_bits-2:0], 1'b0};
      end
      primed <= 1'b1;
    end
  end

  assign o_mosi = shreg[spi_frame_pkg::dac_frame_bits-1];

  // incoming bits, MSB first, sampled at mid-bit
  always_ff @(posedge lclk) begin
    if (i_mid_tick) begin
      cap.raw <= {cap.raw[spi_frame_pkg::adc_frame_bits-2:0], i_miso};
    end
  end

  assign o_capture = cap;

endmodule

`default_nettype wire
